// File: hw/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and memory sizes
`define DATA_WIDTH      8
`define ADDR_WIDTH      16
`define MEMORY_DEPTH    256
`define MEM_ADDR_WIDTH  8
`define ALU_OP_WIDTH    5
`define BUS_ID_WIDTH    3
`define NUM_BUS_IDS     8
`define STATUS_WIDTH    4

// Opcode word fields
`define OPW_TYPE_RANGE  7:6
`define OPW_MID_RANGE   5:3
`define OPW_SID_RANGE   2:0
`define OPW_FUNC_RANGE  4:0

// ALU function codes, LD passes B through
`define ALU_LD          5'h00
`define ALU_ADD         5'h01
`define ALU_SUB         5'h02
`define ALU_AND         5'h03
`define ALU_OR          5'h04
`define ALU_XOR         5'h05
`define ALU_NOT         5'h06
`define ALU_SHL         5'h07
`define ALU_SHR         5'h08

// System function codes
`define SYS_HLT         5'h00
`define SYS_INC_AR      5'h01
`define SYS_OUT         5'h02
`define SYS_OUTS        5'h03

// Data bus master and slave IDs
`define ID_IR           3'd0
`define ID_MEM          3'd1
`define ID_A            3'd2
`define ID_B            3'd3
`define ID_AR0          3'd4
`define ID_AR1          3'd5
`define ID_PC0          3'd6
`define ID_PC1          3'd7

`endif

// File: hw/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	// One byte on the internal data bus
	typedef logic [`DATA_WIDTH-1:0] data_t;

	// Full address held by PC and AR
	typedef logic [`ADDR_WIDTH-1:0] addr_t;

	// ALU function field of the opcode word
	typedef logic [`ALU_OP_WIDTH-1:0] alu_op_t;

	// Bus master or slave select
	typedef logic [`BUS_ID_WIDTH-1:0] bus_id_t;

	// Zero, carry, negative, overflow from bit 3 down to bit 0
	typedef logic [`STATUS_WIDTH-1:0] status_t;

	// Two-state instruction timer
	typedef enum logic {
		TS_T0 = 1'b0,
		TS_T1 = 1'b1
	} tstate_e;

	// Top two bits of the opcode word
	typedef enum logic [1:0] {
		OP_MOV = 2'd0,
		OP_MVI = 2'd1,
		OP_ALU = 2'd2,
		OP_SYS = 2'd3
	} op_type_e;

endpackage

// File: hw/alu.sv
`include "cpu_defs.svh"

module alu (
	input  cpu_pkg::data_t   a,
	input  cpu_pkg::data_t   b,
	input  cpu_pkg::alu_op_t op,
	output cpu_pkg::data_t   result,
	output cpu_pkg::status_t status
);
	// One extra bit to catch carry or borrow
	logic [`DATA_WIDTH:0] sum;
	logic                 carry;
	logic                 ovf;

	always_comb begin
		sum    = '0;
		carry  = 1'b0;
		ovf    = 1'b0;
		result = b;
		case (op)
			`ALU_ADD: begin
				sum    = {1'b0, a} + {1'b0, b};
				result = sum[`DATA_WIDTH-1:0];
				carry  = sum[`DATA_WIDTH];
				// Same-sign operands, result sign flipped
				ovf    = (a[`DATA_WIDTH-1] == b[`DATA_WIDTH-1]) &&
				         (result[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
			end
			`ALU_SUB: begin
				sum    = {1'b0, a} - {1'b0, b};
				result = sum[`DATA_WIDTH-1:0];
				// Top bit set means borrow
				carry  = sum[`DATA_WIDTH];
				ovf    = (a[`DATA_WIDTH-1] != b[`DATA_WIDTH-1]) &&
				         (result[`DATA_WIDTH-1] != a[`DATA_WIDTH-1]);
			end
			`ALU_AND: result = a & b;
			`ALU_OR:  result = a | b;
			`ALU_XOR: result = a ^ b;
			`ALU_NOT: result = ~a;
			`ALU_SHL: begin
				result = {a[`DATA_WIDTH-2:0], 1'b0};
				carry  = a[`DATA_WIDTH-1];
			end
			`ALU_SHR: begin
				result = {1'b0, a[`DATA_WIDTH-1:1]};
				carry  = a[0];
			end
			// LD and unused codes pass B
			default: result = b;
		endcase
	end

	// Zero and negative always follow the result
	assign status = {(result == '0), carry, result[`DATA_WIDTH-1], ovf};

endmodule

// File: hw/addr_register.sv
`include "cpu_defs.svh"

module addr_register (
	input  logic           clk,
	input  logic           rst,
	input  cpu_pkg::data_t data,
	input  logic           we_lo,
	input  logic           we_hi,
	input  logic           inc,
	output cpu_pkg::addr_t addr
);
	// Incremented address, wraps at the top
	cpu_pkg::addr_t addr_next;

	assign addr_next = addr + cpu_pkg::addr_t'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= '0;
		end else if (we_lo) begin
			// Byte loads beat the counter
			addr[`DATA_WIDTH-1:0] <= data;
		end else if (we_hi) begin
			addr[`ADDR_WIDTH-1:`DATA_WIDTH] <= data;
		end else if (inc) begin
			addr <= addr_next;
		end
	end

endmodule

// File: hw/memory.sv
`include "cpu_defs.svh"

module memory (
	input  logic                       clk,
	input  logic [`MEM_ADDR_WIDTH-1:0] addr,
	input  cpu_pkg::data_t             wdata,
	input  logic                       we,
	output cpu_pkg::data_t             rdata,
	input  logic                       load_en,
	input  logic [`MEM_ADDR_WIDTH-1:0] load_addr,
	input  cpu_pkg::data_t             load_data
);
	// Program and data share this array
	cpu_pkg::data_t mem [`MEMORY_DEPTH];

	// Async read, visible in the same cycle
	assign rdata = mem[addr];

	// Single write port, program load wins
	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end else if (we) begin
			mem[addr] <= wdata;
		end
	end

endmodule

// File: hw/control_unit.sv
`include "cpu_defs.svh"

module control_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             hlt,
	input  cpu_pkg::data_t   ir,
	output cpu_pkg::tstate_e tstate,
	output cpu_pkg::bus_id_t mid,
	output cpu_pkg::bus_id_t sid,
	output logic             bus_en,
	output cpu_pkg::alu_op_t alu_op,
	output logic             alu_en,
	output logic             pc_inc,
	output logic             ar_inc,
	output logic             addr_sel,
	output logic             out_a,
	output logic             out_s,
	output logic             halted
);
	cpu_pkg::op_type_e op_type;
	cpu_pkg::bus_id_t  ir_mid;
	cpu_pkg::bus_id_t  ir_sid;
	cpu_pkg::alu_op_t  ir_func;
	logic              fetch_ok;
	logic              hlt_exec;

	// Opcode word fields
	assign op_type = cpu_pkg::op_type_e'(ir[`OPW_TYPE_RANGE]);
	assign ir_mid  = ir[`OPW_MID_RANGE];
	assign ir_sid  = ir[`OPW_SID_RANGE];
	assign ir_func = ir[`OPW_FUNC_RANGE];

	// Pause pin or HLT both freeze the fetch
	assign fetch_ok = ~hlt & ~halted;

	assign hlt_exec = (tstate == cpu_pkg::TS_T1) && (op_type == cpu_pkg::OP_SYS) &&
	                  (ir_func == `SYS_HLT);

	// T-state timer, sits in T0 while paused
	always_ff @(posedge clk) begin
		if (rst) begin
			tstate <= cpu_pkg::TS_T0;
		end else if (tstate == cpu_pkg::TS_T1) begin
			tstate <= cpu_pkg::TS_T0;
		end else if (fetch_ok) begin
			tstate <= cpu_pkg::TS_T1;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			halted <= 1'b0;
		end else if (hlt_exec) begin
			halted <= 1'b1;
		end
	end

	always_comb begin
		// Idle defaults, MEM to IR with PC address
		mid      = `ID_MEM;
		sid      = `ID_IR;
		bus_en   = 1'b0;
		alu_op   = `ALU_LD;
		alu_en   = 1'b0;
		pc_inc   = 1'b0;
		ar_inc   = 1'b0;
		addr_sel = 1'b0;
		out_a    = 1'b0;
		out_s    = 1'b0;
		if (tstate == cpu_pkg::TS_T0) begin
			// Opcode fetch
			bus_en = fetch_ok;
			pc_inc = fetch_ok;
		end else begin
			case (op_type)
				cpu_pkg::OP_MOV: begin
					mid    = ir_mid;
					sid    = ir_sid;
					bus_en = 1'b1;
					// RAM on either side goes through AR
					addr_sel = (ir_mid == `ID_MEM) || (ir_sid == `ID_MEM);
				end
				cpu_pkg::OP_MVI: begin
					// Immediate byte sits at PC
					sid    = ir_sid;
					bus_en = 1'b1;
					pc_inc = 1'b1;
				end
				cpu_pkg::OP_ALU: begin
					alu_op = ir_func;
					alu_en = 1'b1;
				end
				default: begin
					case (ir_func)
						`SYS_INC_AR: ar_inc = 1'b1;
						`SYS_OUT:    out_a  = 1'b1;
						`SYS_OUTS:   out_s  = 1'b1;
						// HLT handled by the halted flop
						default:     ar_inc = 1'b0;
					endcase
				end
			endcase
		end
	end

endmodule

// File: hw/cpu_top.sv
`include "cpu_defs.svh"

module cpu_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       hlt,
	input  logic                       load_en,
	input  logic [`MEM_ADDR_WIDTH-1:0] load_addr,
	input  cpu_pkg::data_t             load_data,
	output cpu_pkg::data_t             out_data,
	output logic                       out_valid,
	output logic                       halted
);
	cpu_pkg::tstate_e tstate;
	cpu_pkg::bus_id_t mid;
	cpu_pkg::bus_id_t sid;
	logic             bus_en;
	cpu_pkg::alu_op_t alu_op;
	logic             alu_en;
	logic             pc_inc;
	logic             ar_inc;
	logic             addr_sel;
	logic             out_a;
	logic             out_s;

	cpu_pkg::data_t   data_bus;
	cpu_pkg::data_t   a_reg;
	cpu_pkg::data_t   b_reg;
	cpu_pkg::data_t   ir_reg;
	cpu_pkg::status_t status;
	cpu_pkg::data_t   alu_result;
	cpu_pkg::status_t alu_status;
	cpu_pkg::data_t   mem_rdata;
	cpu_pkg::addr_t   pc;
	cpu_pkg::addr_t   ar;
	logic [`NUM_BUS_IDS-1:0]    we;
	logic [`MEM_ADDR_WIDTH-1:0] mem_addr;

	control_unit u_ctrl (
		.clk(clk), .rst(rst), .hlt(hlt),
		.ir(ir_reg), .tstate(tstate),
		.mid(mid), .sid(sid), .bus_en(bus_en),
		.alu_op(alu_op), .alu_en(alu_en),
		.pc_inc(pc_inc), .ar_inc(ar_inc), .addr_sel(addr_sel),
		.out_a(out_a), .out_s(out_s), .halted(halted)
	);

	// Master select, one source on the bus
	always_comb begin
		case (mid)
			`ID_IR:  data_bus = ir_reg;
			`ID_MEM: data_bus = mem_rdata;
			`ID_A:   data_bus = a_reg;
			`ID_B:   data_bus = b_reg;
			`ID_AR0: data_bus = ar[`DATA_WIDTH-1:0];
			`ID_AR1: data_bus = ar[`ADDR_WIDTH-1:`DATA_WIDTH];
			`ID_PC0: data_bus = pc[`DATA_WIDTH-1:0];
			default: data_bus = pc[`ADDR_WIDTH-1:`DATA_WIDTH];
		endcase
	end

	// Slave write enables, one-hot on sid
	assign we = bus_en ? (`NUM_BUS_IDS'(1) << sid) : '0;

	alu u_alu (
		.a(a_reg), .b(b_reg), .op(alu_op),
		.result(alu_result), .status(alu_status)
	);

	// Accumulator, ALU result beats a bus write
	always_ff @(posedge clk) begin
		if (rst) begin
			a_reg <= '0;
		end else if (alu_en) begin
			a_reg <= alu_result;
		end else if (we[`ID_A]) begin
			a_reg <= data_bus;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			b_reg <= '0;
		end else if (we[`ID_B]) begin
			b_reg <= data_bus;
		end
	end

	// IR only loads on a fetch
	always_ff @(posedge clk) begin
		if (rst) begin
			ir_reg <= '0;
		end else if (we[`ID_IR] && (tstate == cpu_pkg::TS_T0)) begin
			ir_reg <= data_bus;
		end
	end

	// Flags kept across LD
	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (alu_en && (alu_op != `ALU_LD)) begin
			status <= alu_status;
		end
	end

	addr_register pc_reg (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we[`ID_PC0]), .we_hi(we[`ID_PC1]),
		.inc(pc_inc), .addr(pc)
	);

	addr_register ar_reg (
		.clk(clk), .rst(rst), .data(data_bus),
		.we_lo(we[`ID_AR0]), .we_hi(we[`ID_AR1]),
		.inc(ar_inc), .addr(ar)
	);

	// Low byte of AR or PC addresses the RAM
	assign mem_addr = addr_sel ? ar[`MEM_ADDR_WIDTH-1:0] : pc[`MEM_ADDR_WIDTH-1:0];

	memory u_ram (
		.clk(clk), .addr(mem_addr), .wdata(data_bus),
		.we(we[`ID_MEM]), .rdata(mem_rdata),
		.load_en(load_en & rst), .load_addr(load_addr), .load_data(load_data)
	);

	// Output strobe, one cycle per OUT or OUTS
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= out_a | out_s;
		end
	end

	always_ff @(posedge clk) begin
		if (out_a) begin
			out_data <= a_reg;
		end else if (out_s) begin
			// Flags zero-extended into the low nibble
			out_data <= cpu_pkg::data_t'(status);
		end
	end

endmodule

// File: bench/tb_clock.sv
module tb_clock (
	input  logic load_done,
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 8;

	int unsigned hold_count = 0;
	logic        rst_q      = 1'b1;

	assign rst = rst_q;

	// 10 ns period
	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Reset stays on 8 more cycles once the program is in RAM
	always @(posedge clk) begin
		if (load_done) begin
			if (hold_count == RESET_CYCLES - 1) begin
				rst_q <= 1'b0;
			end else begin
				hold_count <= hold_count + 1;
			end
		end
	end

endmodule

// File: bench/cpu_sva.sv
module cpu_sva (
	input logic             clk,
	input logic             rst,
	input logic             hlt,
	input cpu_pkg::tstate_e tstate,
	input logic             out_valid,
	input logic             halted
);
	timeunit 1ns;
	timeprecision 100ps;

	// One sticky flag per property
	logic halt_dropped = 1'b0;
	logic strobe_halted = 1'b0;
	logic strobe_long = 1'b0;
	logic reset_dirty = 1'b0;
	logic pause_broken = 1'b0;
	logic failed;

	assign failed = halt_dropped | strobe_halted | strobe_long | reset_dirty | pause_broken;

	// Halt holds until the next reset
	halt_sticky: assert property (@(posedge clk) (halted && !rst) |=> halted)
		else begin
			halt_dropped = 1'b1;
			$error("halted fell without a reset");
		end

	// A halted core writes nothing to the port
	quiet_when_halted: assert property (@(posedge clk) halted |-> !out_valid)
		else begin
			strobe_halted = 1'b1;
			$error("out_valid high while halted");
		end

	// Single-cycle strobe
	strobe_one_cycle: assert property (@(posedge clk) out_valid |=> !out_valid)
		else begin
			strobe_long = 1'b1;
			$error("out_valid held for more than one cycle");
		end

	// Clean outputs straight out of reset
	reset_clears: assert property (@(posedge clk) rst |=> (!out_valid && !halted))
		else begin
			reset_dirty = 1'b1;
			$error("out_valid or halted set after reset");
		end

	// Pause pin freezes the timer in T0
	pause_holds: assert property (@(posedge clk)
		(hlt && (tstate == cpu_pkg::TS_T0)) |=> (tstate == cpu_pkg::TS_T0))
		else begin
			pause_broken = 1'b1;
			$error("timer left T0 while hlt was high");
		end

endmodule

bind cpu_top cpu_sva u_sva (
	.clk(clk),
	.rst(rst),
	.hlt(hlt),
	.tstate(tstate),
	.out_valid(out_valid),
	.halted(halted)
);

// File: bench/cpu_tb.sv
`include "cpu_defs.svh"

module cpu_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PAUSE_START = 40;
	localparam int PAUSE_LEN   = 6;

	logic                       clk;
	logic                       rst;
	logic                       load_done = 1'b0;
	logic                       hlt       = 1'b0;
	logic                       load_en   = 1'b0;
	logic [`MEM_ADDR_WIDTH-1:0] load_addr = '0;
	cpu_pkg::data_t             load_data = '0;
	cpu_pkg::data_t             out_data;
	logic                       out_valid;
	logic                       halted;

	// Program image and instruction count
	cpu_pkg::data_t prog [`MEMORY_DEPTH];
	int             prog_len = 0;
	int             n_instr  = 0;
	logic [31:0]    lfsr_state = 32'he080_4595;

	// Reference machine state
	cpu_pkg::data_t   model_mem [`MEMORY_DEPTH];
	cpu_pkg::data_t   m_a;
	cpu_pkg::data_t   m_b;
	cpu_pkg::data_t   m_ir;
	cpu_pkg::addr_t   m_pc;
	cpu_pkg::addr_t   m_ar;
	cpu_pkg::status_t m_status;
	cpu_pkg::data_t   expected_q [$];

	int cycle_count = 0;
	int cycle_limit = 100000;

	tb_clock u_clock (.load_done(load_done), .clk(clk), .rst(rst));

	cpu_top dut0 (
		.clk(clk), .rst(rst), .hlt(hlt),
		.load_en(load_en), .load_addr(load_addr), .load_data(load_data),
		.out_data(out_data), .out_valid(out_valid), .halted(halted)
	);

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// Galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic cpu_pkg::data_t take_bits(int n);
		cpu_pkg::data_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr_state[0]};
			lfsr_state = next_lfsr(lfsr_state);
		end
		return v;
	endfunction

	function automatic cpu_pkg::data_t func_word(cpu_pkg::op_type_e kind,
	                                             cpu_pkg::alu_op_t f);
		cpu_pkg::data_t op;
		op = '0;
		op[`OPW_TYPE_RANGE] = kind;
		op[`OPW_FUNC_RANGE] = f;
		return op;
	endfunction

	task automatic put_byte(cpu_pkg::data_t v);
		prog[prog_len[7:0]] = v;
		prog_len++;
	endtask

	task automatic put_instr(cpu_pkg::data_t op);
		put_byte(op);
		n_instr++;
	endtask

	task automatic put_mov(cpu_pkg::bus_id_t src, cpu_pkg::bus_id_t dst);
		cpu_pkg::data_t op;
		op = '0;
		op[`OPW_TYPE_RANGE] = cpu_pkg::OP_MOV;
		op[`OPW_MID_RANGE]  = src;
		op[`OPW_SID_RANGE]  = dst;
		put_instr(op);
	endtask

	task automatic put_mvi(cpu_pkg::bus_id_t dst, cpu_pkg::data_t imm);
		cpu_pkg::data_t op;
		op = '0;
		op[`OPW_TYPE_RANGE] = cpu_pkg::OP_MVI;
		op[`OPW_SID_RANGE]  = dst;
		put_instr(op);
		put_byte(imm);
	endtask

	task automatic put_alu(cpu_pkg::alu_op_t f);
		put_instr(func_word(cpu_pkg::OP_ALU, f));
	endtask

	task automatic put_sys(cpu_pkg::alu_op_t f);
		put_instr(func_word(cpu_pkg::OP_SYS, f));
	endtask

	task automatic build_program();
		cpu_pkg::data_t base;
		// Fill bytes follow the full address
		for (int i = 0; i < `MEMORY_DEPTH; i++) begin
			prog[i[7:0]] = i[7:0] ^ 8'h5a;
		end
		// First fetch from address 0
		put_mvi(`ID_A, take_bits(8));
		put_sys(`SYS_OUT);
		// Every ALU function on fresh operands, result then flags
		for (int f = 0; f < 9; f++) begin
			put_mvi(`ID_A, take_bits(8));
			put_mvi(`ID_B, take_bits(8));
			put_alu(cpu_pkg::alu_op_t'(f));
			put_sys(`SYS_OUT);
			put_sys(`SYS_OUTS);
		end
		put_alu(cpu_pkg::alu_op_t'(take_bits(3)));
		put_sys(`SYS_OUT);
		// Two stores through AR, read back in order
		base = 8'hc0 | take_bits(5);
		put_mvi(`ID_AR0, base);
		put_mvi(`ID_AR1, take_bits(8));
		put_mvi(`ID_A, take_bits(8));
		put_mov(`ID_A, `ID_MEM);
		put_sys(`SYS_INC_AR);
		put_mvi(`ID_A, take_bits(8));
		put_mov(`ID_A, `ID_MEM);
		put_mvi(`ID_AR0, base);
		put_mov(`ID_MEM, `ID_B);
		put_alu(`ALU_LD);
		put_sys(`SYS_OUT);
		put_sys(`SYS_INC_AR);
		put_mov(`ID_MEM, `ID_B);
		put_alu(`ALU_LD);
		put_sys(`SYS_OUT);
		// High byte of AR, then PC just past an MVI
		put_mov(`ID_AR1, `ID_A);
		put_sys(`SYS_OUT);
		put_mvi(`ID_B, take_bits(8));
		put_mov(`ID_PC0, `ID_A);
		put_sys(`SYS_OUT);
		put_sys(`SYS_HLT);
		// Dead code past HLT, never counted
		put_byte(8'h42);
		put_byte(take_bits(8));
		put_byte(func_word(cpu_pkg::OP_SYS, `SYS_OUT));
	endtask

	function automatic cpu_pkg::data_t read_source(cpu_pkg::bus_id_t id);
		case (id)
			`ID_IR:  return m_ir;
			`ID_MEM: return model_mem[m_ar[7:0]];
			`ID_A:   return m_a;
			`ID_B:   return m_b;
			`ID_AR0: return m_ar[7:0];
			`ID_AR1: return m_ar[15:8];
			`ID_PC0: return m_pc[7:0];
			default: return m_pc[15:8];
		endcase
	endfunction

	task automatic write_dest(cpu_pkg::bus_id_t id, cpu_pkg::data_t v);
		case (id)
			`ID_MEM: model_mem[m_ar[7:0]] = v;
			`ID_A:   m_a = v;
			`ID_B:   m_b = v;
			`ID_AR0: m_ar[7:0] = v;
			`ID_AR1: m_ar[15:8] = v;
			`ID_PC0: m_pc[7:0] = v;
			`ID_PC1: m_pc[15:8] = v;
			// IR as a slave takes no write
			default: ;
		endcase
	endtask

	task automatic exec_alu(cpu_pkg::alu_op_t f);
		int             wide;
		int             sr;
		logic           c;
		logic           v;
		cpu_pkg::data_t r;
		c  = 1'b0;
		v  = 1'b0;
		r  = m_b;
		case (f)
			`ALU_ADD: begin
				wide = int'(m_a) + int'(m_b);
				r    = wide[7:0];
				c    = (wide > 255);
				sr   = int'($signed(m_a)) + int'($signed(m_b));
				v    = (sr > 127) || (sr < -128);
			end
			`ALU_SUB: begin
				r  = m_a - m_b;
				// Borrow
				c  = (m_a < m_b);
				sr = int'($signed(m_a)) - int'($signed(m_b));
				v  = (sr > 127) || (sr < -128);
			end
			`ALU_AND: r = m_a & m_b;
			`ALU_OR:  r = m_a | m_b;
			`ALU_XOR: r = m_a ^ m_b;
			`ALU_NOT: r = ~m_a;
			`ALU_SHL: begin
				r = {m_a[6:0], 1'b0};
				c = m_a[7];
			end
			`ALU_SHR: begin
				r = {1'b0, m_a[7:1]};
				c = m_a[0];
			end
			default: r = m_b;
		endcase
		m_a = r;
		// LD keeps the old flags
		if (f != `ALU_LD) begin
			m_status = {(r == 8'h00), c, r[7], v};
		end
	endtask

	// Instruction-level run of the image, fills the expected queue
	task automatic run_model();
		cpu_pkg::data_t v;
		logic           done;
		for (int i = 0; i < `MEMORY_DEPTH; i++) begin
			model_mem[i[7:0]] = prog[i[7:0]];
		end
		m_a      = '0;
		m_b      = '0;
		m_ir     = '0;
		m_pc     = '0;
		m_ar     = '0;
		m_status = '0;
		done     = 1'b0;
		for (int step = 0; (step < `MEMORY_DEPTH) && !done; step++) begin
			m_ir = model_mem[m_pc[7:0]];
			m_pc = m_pc + 16'd1;
			case (cpu_pkg::op_type_e'(m_ir[`OPW_TYPE_RANGE]))
				cpu_pkg::OP_MOV: begin
					write_dest(m_ir[`OPW_SID_RANGE], read_source(m_ir[`OPW_MID_RANGE]));
				end
				cpu_pkg::OP_MVI: begin
					v    = model_mem[m_pc[7:0]];
					m_pc = m_pc + 16'd1;
					write_dest(m_ir[`OPW_SID_RANGE], v);
				end
				cpu_pkg::OP_ALU: exec_alu(m_ir[`OPW_FUNC_RANGE]);
				default: begin
					case (m_ir[`OPW_FUNC_RANGE])
						`SYS_HLT:    done = 1'b1;
						`SYS_INC_AR: m_ar = m_ar + 16'd1;
						`SYS_OUT:    expected_q.push_back(m_a);
						`SYS_OUTS:   expected_q.push_back({4'b0000, m_status});
						default: ;
					endcase
				end
			endcase
		end
	endtask

	initial begin
		build_program();
		run_model();
		// Load, reset and post-halt wait fit in the 16
		cycle_limit = `MEMORY_DEPTH + 16 + 2 * n_instr + PAUSE_LEN + 20;
		// Whole RAM through the load port while rst is high
		for (int i = 0; i < `MEMORY_DEPTH; i++) begin
			@(posedge clk);
			load_en   <= 1'b1;
			load_addr <= i[7:0];
			load_data <= prog[i[7:0]];
		end
		@(posedge clk);
		load_en   <= 1'b0;
		load_done <= 1'b1;
		while (rst) @(posedge clk);
		// Pause mid-program
		repeat (PAUSE_START) @(posedge clk);
		hlt <= 1'b1;
		repeat (PAUSE_LEN) @(posedge clk);
		hlt <= 1'b0;
		while (!halted) @(posedge clk);
		// A few idle cycles past HLT for the port checks
		repeat (4) @(posedge clk);
		if (dut0.u_sva.failed) begin
			abort_run("A port assertion on cpu_top failed");
		end else if (expected_q.size() != 0) begin
			abort_run($sformatf("Halted with %0d outputs never seen", expected_q.size()));
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

	// Port check against the model queue
	always @(posedge clk) begin : check_output
		cpu_pkg::data_t want;
		if (dut0.u_sva.failed) begin
			abort_run("A port assertion on cpu_top failed");
		end else if (out_valid && (expected_q.size() == 0)) begin
			abort_run("out_valid pulsed with no output left to expect");
		end else if (out_valid) begin
			want = expected_q.pop_front();
			assert (out_data == want)
				else abort_run($sformatf("Mismatch at %0t ns: out_data is 8'h%h, expected 8'h%h",
				                         $time, out_data, want));
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			abort_run($sformatf("Timeout after %0d cycles with no halt", cycle_count));
		end
	end

endmodule

// File: compile.f
+incdir+hw
hw/cpu_pkg.sv
hw/alu.sv
hw/addr_register.sv
hw/memory.sv
hw/control_unit.sv
hw/cpu_top.sv
bench/tb_clock.sv
bench/cpu_sva.sv
bench/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module cpu_tb -f compile.f -o cpu_sim &&
./obj_dir/cpu_sim +verilator+error+limit+100 | tee /dev/stderr | grep -q "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
